// ==== verif/gl_cases.txt ====
# D op pc result | W port dispatch_no result cause | B dispatch_no
# E pc result | X pc cause | T name expected_empty expected_full
E 00001000 000000a0
E 00001004 000000a1
E 00001008 000000a2
E 0000100c 000000a3
D 0 00001000 00000000
D 4 00001004 00000000
D 1 00001008 00000000
D 4 0000100c 00000000
W 1 3 000000a3 0
W 0 2 000000a2 0
W 1 1 000000a1 0
W 0 0 000000a0 0
T in_order 1 0
E 00002000 00000055
E 00002004 0000cafe
E 00002008 0000beef
D 1 00002000 00000000
D 2 00002004 0000cafe
D 3 00002008 0000beef
W 0 4 00000055 0
T stores 1 0
E 00003000 00000011
X 00003004 2
D 0 00003000 00000000
D 1 00003004 00000000
D 0 00003008 00000000
W 0 9 00000099 0
W 0 7 00000011 0
W 0 8 00000000 2
T exception 1 0
E 00004000 00000021
E 00004004 00000022
E 00004100 00000031
D 0 00004000 00000000
D 5 00004004 00000000
D 0 00004008 00000000
D 4 0000400c 00000000
W 0 12 00000023 0
B 11
D 0 00004100 00000000
W 0 10 00000021 0
W 0 11 00000022 0
W 0 14 00000031 0
T branch 1 0
D 0 00005000 00000000
D 0 00005004 00000000
D 0 00005008 00000000
D 0 0000500c 00000000
D 0 00005010 00000000
D 0 00005014 00000000
D 0 00005018 00000000
D 0 0000501c 00000000
T occupancy_full 0 1
E 00005000 00000040
E 00005004 00000041
E 00005008 00000042
E 0000500c 00000043
E 00005010 00000044
E 00005014 00000045
E 00005018 00000046
W 0 15 00000040 0
W 1 16 00000041 0
W 0 17 00000042 0
W 1 18 00000043 0
W 0 19 00000044 0
W 1 20 00000045 0
W 0 21 00000046 0
T occupancy_drain 1 0

// ==== sim.f ====
logic/gl_pkg.sv
logic/graduation_list.sv
logic/commit_stage.sv
logic/gl_top.sv
verif/gl_top_sva.sv
verif/tb_gl_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gl_top
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Result: failed, see $(LOG)"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Result: passed"; \
	else \
		echo "Result: no verdict found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_gl_top.sv ====
`timescale 1ns/1ps

module tb_gl_top import gl_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int MAX_DISP   = 256;
    localparam int DRAIN_WAIT = 100;        // Cycles a test may take to empty its queue

    typedef struct packed {
        logic            is_exc;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] value;             // Result or exception cause
    } expect_t;

    logic                  clk;
    logic                  rstn;
    gl_entry_t             dispatch;
    gl_index_t             dispatch_index;
    gl_wb_t [NUM_WB-1:0]   wb;
    logic                  flush;
    gl_index_t             flush_index;
    retire_t               retire;
    exc_t                  exc;
    logic [RET_CNT_W-1:0]  retired_count;
    logic                  full;
    logic                  empty;

    expect_t    exp_q[$];
    gl_index_t  idx_tab [MAX_DISP];         // Dispatch number to list index
    logic       idx_ok  [MAX_DISP];         // Cleared when the dispatch was dropped
    gl_index_t  model_tail;                 // Expected slot of the next dispatch
    int         disp_num;
    int         err_count;
    int         test_errs;
    int         tests_run;
    int         tests_failed;
    int         e_total;
    int         case_lines;
    logic [31:0] rng_state;

    gl_top uut (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .dispatch_i      (dispatch),
        .dispatch_index_o(dispatch_index),
        .wb_i            (wb),
        .flush_i         (flush),
        .flush_index_i   (flush_index),
        .retire_o        (retire),
        .exc_o           (exc),
        .retired_count_o (retired_count),
        .full_o          (full),
        .empty_o         (empty)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_gap();
        rng_state = xorshift32(rng_state);
        repeat (rng_state % 3) next_cycle();    // Zero to two idle cycles
    endtask

    task automatic check_value(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        err_count++;
        test_errs++;
    endtask

    task automatic send_dispatch(input op_e op, input logic [XLEN-1:0] pc,
                                 input logic [XLEN-1:0] res);
        check_value(XLEN'(dispatch_index), XLEN'(model_tail), "dispatch index");
        idx_ok[disp_num]  = !full;              // A full list ignores this one
        idx_tab[disp_num] = dispatch_index;
        if (!full) begin
            model_tail = model_tail + gl_index_t'(1);
        end
        dispatch.valid  = 1'b1;
        dispatch.op     = op;
        dispatch.pc     = pc;
        dispatch.result = res;
        dispatch.cause  = EXC_NONE;
        disp_num++;
        next_cycle();
        dispatch.valid = 1'b0;
    endtask

    task automatic send_writeback(input int port, input int num, input logic [XLEN-1:0] res,
                                  input int cause);
        if (!idx_ok[num]) begin
            report_problem($sformatf("Writeback names dispatch %0d, which was dropped", num));
        end
        wb[port].valid  = 1'b1;
        wb[port].index  = idx_tab[num];
        wb[port].result = res;
        wb[port].cause  = exc_cause_e'(cause[1:0]);
        next_cycle();
        wb[port].valid = 1'b0;
    endtask

    task automatic send_flush(input int num);
        if (!empty) begin
            model_tail = idx_tab[num] + gl_index_t'(1);   // Younger entries are dropped
        end
        flush       = 1'b1;
        flush_index = idx_tab[num];             // This entry survives
        next_cycle();
        flush = 1'b0;
    endtask

    task automatic finish_test(input logic [8*24-1:0] name, input int exp_e, input int exp_f);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_WAIT) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_problem($sformatf("Test %0s: %0d expected outputs never arrived",
                                     name, exp_q.size()));
        end
        repeat (4) next_cycle();                // Let a pending flush settle
        check_value(XLEN'(empty), XLEN'(exp_e), "empty flag");
        check_value(XLEN'(full), XLEN'(exp_f), "full flag");
        check_value(XLEN'(retired_count), XLEN'(e_total), "retired count");
        tests_run++;
        if (test_errs == 0) begin
            $display("Test %0s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %0s: failed with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    // Compare every strobe with the oldest expectation
    always @(negedge clk) begin
        expect_t exp_head;
        if (rstn && (retire.valid || exc.valid)) begin
            if (exc.valid) begin
                model_tail = '0;                // Exception empties the list
            end
            if (exp_q.size() == 0) begin
                report_problem($sformatf("Unexpected output at pc %h when none was expected",
                                         exc.valid ? exc.pc : retire.pc));
            end else begin
                exp_head = exp_q.pop_front();
                check_value(XLEN'(exc.valid), XLEN'(exp_head.is_exc), "output kind");
                if (exc.valid) begin
                    check_value(exc.pc, exp_head.pc, "exception pc");
                    check_value(XLEN'(exc.cause), exp_head.value, "exception cause");
                end else begin
                    check_value(retire.pc, exp_head.pc, "retire pc");
                    check_value(retire.result, exp_head.value, "retire result");
                end
            end
        end
    end

    initial begin
        int fd;
        int code;
        int op;
        int port;
        int num;
        int cause_v;
        int exp_e;
        int exp_f;
        logic [7:0]       ch;
        logic [8*128-1:0] rest;
        logic [8*24-1:0]  name;
        logic [XLEN-1:0]  pc_v;
        logic [XLEN-1:0]  val_v;
        logic             more;

        rstn = 1'b0;
        dispatch = '0;
        wb = '0;
        flush = 1'b0;
        flush_index = '0;
        model_tail = '0;
        disp_num = 0;
        err_count = 0;
        test_errs = 0;
        tests_run = 0;
        tests_failed = 0;
        e_total = 0;
        case_lines = 0;
        rng_state = 32'hd7f9_6936;
        for (int i = 0; i < MAX_DISP; i++) begin
            idx_ok[i] = 1'b0;
        end

        fd = $fopen("verif/gl_cases.txt", "r");
        if (fd == 0) begin
            report_problem("Cannot open verif/gl_cases.txt, no tests were run");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(rest, fd);
                if (code > 0) case_lines++;        // Sizes the watchdog
            end
            $fclose(fd);
        end

        repeat (4) @(posedge clk);
        #1 rstn = 1'b1;
        next_cycle();

        fd = $fopen("verif/gl_cases.txt", "r");
        more = (fd != 0);
        while (more) begin
            code = $fscanf(fd, " %c", ch);
            if (code != 1) begin
                more = 1'b0;
            end else begin
                case (ch)
                    "#": code = $fgets(rest, fd);
                    "D": begin
                        code = $fscanf(fd, "%d %h %h", op, pc_v, val_v);
                        send_dispatch(op_e'(op[2:0]), pc_v, val_v);
                        idle_gap();
                    end
                    "W": begin
                        code = $fscanf(fd, "%d %d %h %d", port, num, val_v, cause_v);
                        send_writeback(port, num, val_v, cause_v);
                        idle_gap();
                    end
                    "B": begin
                        code = $fscanf(fd, "%d", num);
                        send_flush(num);
                        idle_gap();
                    end
                    "E": begin
                        code = $fscanf(fd, "%h %h", pc_v, val_v);
                        exp_q.push_back({1'b0, pc_v, val_v});
                        e_total++;
                    end
                    "X": begin
                        code = $fscanf(fd, "%h %d", pc_v, cause_v);
                        exp_q.push_back({1'b1, pc_v, XLEN'(cause_v)});
                    end
                    "T": begin
                        code = $fscanf(fd, "%s %d %d", name, exp_e, exp_f);
                        finish_test(name, exp_e, exp_f);
                    end
                    default: report_problem($sformatf("Unknown command %c in cases file", ch));
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        err_count += uut.u_gl_top_sva.assert_fails;
        $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Run limit of fifty cycles per case line
    initial begin
        wait (case_lines > 0);
        #(case_lines * 50 * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not complete", case_lines * 50);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== verif/gl_top_sva.sv ====
`timescale 1ns/1ps

module gl_top_sva import gl_pkg::*; (
    input logic       clk_i,
    input logic       rstn_i,
    input gl_entry_t  dispatch_i,
    input gl_index_t  dispatch_index_i,
    input logic       flush_i,
    input logic       flush_all_i,      // Internal exception flush
    input retire_t    retire_i,
    input exc_t       exc_i,
    input logic       full_i,
    input logic       empty_i
);

    int assert_fails = 0;               // Failure count read by the testbench

    // A head entry either retires or traps
    one_outcome: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(retire_i.valid && exc_i.valid))
    else begin
        $error("Retire and exception strobes valid in the same cycle");
        assert_fails++;
    end

    flags_exclusive: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(full_i && empty_i))
    else begin
        $error("Full and empty flags high together");
        assert_fails++;
    end

    // Tail must not move for a dispatch into a full list
    full_blocks_dispatch: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (dispatch_i.valid && full_i && !flush_i && !flush_all_i) |=> $stable(dispatch_index_i))
    else begin
        $error("Dispatch accepted while the list was full");
        assert_fails++;
    end

endmodule

bind gl_top gl_top_sva u_gl_top_sva (
    .clk_i            (clk_i),
    .rstn_i           (rstn_i),
    .dispatch_i       (dispatch_i),
    .dispatch_index_i (dispatch_index_o),
    .flush_i          (flush_i),
    .flush_all_i      (flush_all),
    .retire_i         (retire_o),
    .exc_i            (exc_o),
    .full_i           (full_o),
    .empty_i          (empty_o)
);

// ==== logic/gl_top.sv ====
`timescale 1ns/1ps

// Graduation stage, list plus commit logic
module gl_top import gl_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    input  gl_entry_t             dispatch_i,
    output gl_index_t             dispatch_index_o,

    input  gl_wb_t [NUM_WB-1:0]   wb_i,             // Port 0 scalar, port 1 FP

    input  logic                  flush_i,          // Branch mispredict
    input  gl_index_t             flush_index_i,

    output retire_t               retire_o,
    output exc_t                  exc_o,
    output logic [RET_CNT_W-1:0]  retired_count_o,

    output logic                  full_o,
    output logic                  empty_o
);

    logic       read_head;
    logic       flush_all;
    gl_entry_t  head_entry;

    graduation_list #(
        .NUM_ENTRIES   (GL_ENTRIES)
    ) u_graduation_list (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .entry_i       (dispatch_i),
        .tail_index_o  (dispatch_index_o),
        .wb_i          (wb_i),
        .flush_i       (flush_i),
        .flush_index_i (flush_index_i),
        .flush_all_i   (flush_all),
        .read_head_i   (read_head),
        .head_entry_o  (head_entry),
        .full_o        (full_o),
        .empty_o       (empty_o)
    );

    commit_stage u_commit_stage (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .head_entry_i    (head_entry),
        .read_head_o     (read_head),
        .flush_all_o     (flush_all),
        .retire_o        (retire_o),
        .exc_o           (exc_o),
        .retired_count_o (retired_count_o)
    );

endmodule

// ==== logic/commit_stage.sv ====
`timescale 1ns/1ps

// Turns entries read from the head of the graduation list into
// retirements or exceptions, one per cycle at most
module commit_stage import gl_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    // From the graduation list
    input  gl_entry_t             head_entry_i,

    // To the graduation list
    output logic                  read_head_o,
    output logic                  flush_all_o,    // One-cycle strobe on exception

    // Architectural side
    output retire_t               retire_o,
    output exc_t                  exc_o,
    output logic [RET_CNT_W-1:0]  retired_count_o
);

    logic                  kill_q;                // Next read is wrong path
    logic                  head_live;
    logic                  exc_fire;
    logic                  retire_fire;
    logic [RET_CNT_W-1:0]  retired_count_q;

    // An entry read right behind an exception must not graduate
    assign head_live   = head_entry_i.valid & ~kill_q;

    assign exc_fire    = head_live & (head_entry_i.cause != EXC_NONE);
    assign retire_fire = head_live & (head_entry_i.cause == EXC_NONE);

    // Stop draining the list while the trap is being taken
    assign read_head_o = ~exc_fire;
    assign flush_all_o = exc_fire;

    always_comb begin
        retire_o.valid  = retire_fire;
        retire_o.pc     = head_entry_i.pc;
        retire_o.result = head_entry_i.result;
    end

    always_comb begin
        exc_o.valid = exc_fire;
        exc_o.pc    = head_entry_i.pc;
        exc_o.cause = head_entry_i.cause;
    end

    // Kill window is exactly the cycle after the exception
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            kill_q <= 1'b0;
        end else begin
            kill_q <= exc_fire;
        end
    end

    // Retired instruction counter, wraps silently
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            retired_count_q <= '0;
        end else if (retire_fire) begin
            retired_count_q <= retired_count_q + RET_CNT_W'(1);
        end
    end

    assign retired_count_o = retired_count_q;

endmodule

// ==== logic/graduation_list.sv ====
`timescale 1ns/1ps

// Circular buffer of in-flight instructions kept in program order.
// The depth must match the width of gl_index_t so pointers wrap naturally.
module graduation_list import gl_pkg::*; #(
    parameter int NUM_ENTRIES = GL_ENTRIES
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,

    // Dispatch side
    input  gl_entry_t              entry_i,        // Valid bit is the dispatch strobe
    output gl_index_t              tail_index_o,   // Slot the current dispatch lands in

    // Out-of-order completion
    input  gl_wb_t [NUM_WB-1:0]    wb_i,

    // Branch recovery keeps flush_index_i and everything older
    input  logic                   flush_i,
    input  gl_index_t              flush_index_i,

    // Commit side
    input  logic                   flush_all_i,    // Exception flush drops everything
    input  logic                   read_head_i,
    output gl_entry_t              head_entry_o,   // Valid for one cycle per read

    // Occupancy
    output logic                   full_o,
    output logic                   empty_o
);

    gl_entry_t                entries [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0]   finished;            // Result is present for this slot

    gl_index_t                head;
    gl_index_t                tail;
    logic [CNT_W-1:0]         count;

    gl_index_t                head_nxt;
    gl_index_t                flush_tail;

    logic                     write_en;
    logic                     read_en;
    logic                     is_store_or_amo;

    gl_entry_t                head_data_q;         // Payload of the last read
    logic                     head_vld_q;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(NUM_ENTRIES - 1));

    // A branch flush or an exception wins over a new dispatch
    assign write_en = entry_i.valid & ~full_o & ~flush_i & ~flush_all_i;

    // Branch flush still lets the oldest entry graduate in the same cycle
    assign read_en  = read_head_i & ~empty_o & finished[head] & ~flush_all_i;

    // Stores and atomics have no result to wait for here
    assign is_store_or_amo = (entry_i.op inside {OP_STORE, OP_AMO});

    assign head_nxt   = head + gl_index_t'(read_en);
    assign flush_tail = flush_index_i + gl_index_t'(1);

    // Entry storage written by dispatch and by the writeback ports
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            entries[tail] <= entry_i;
        end
        for (int i = 0; i < NUM_WB; i++) begin
            if (wb_i[i].valid && !flush_all_i) begin
                entries[wb_i[i].index].result <= wb_i[i].result;
                entries[wb_i[i].index].cause  <= wb_i[i].cause;
            end
        end
    end

    // Finished bits
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            finished <= '0;
        end else if (flush_all_i) begin
            finished <= '0;
        end else begin
            if (write_en) begin
                finished[tail] <= is_store_or_amo;
            end
            for (int i = 0; i < NUM_WB; i++) begin
                if (wb_i[i].valid) begin
                    finished[wb_i[i].index] <= 1'b1;
                end
            end
        end
    end

    // Head, tail and occupancy
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_all_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_i && !empty_o) begin
            head  <= head_nxt;
            tail  <= flush_tail;          // Everything younger is gone
            count <= {1'b0, gl_index_t'(flush_tail - head_nxt)}; // Modulo depth
        end else begin
            head  <= head_nxt;
            tail  <= tail + gl_index_t'(write_en);
            count <= count + CNT_W'(write_en) - CNT_W'(read_en);
        end
    end

    // Head read strobe
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_vld_q <= 1'b0;
        end else begin
            head_vld_q <= read_en;
        end
    end

    // Head read payload
    always_ff @(posedge clk_i) begin
        if (read_en) begin
            head_data_q <= entries[head];
        end
    end

    always_comb begin
        head_entry_o       = head_data_q;
        head_entry_o.valid = head_vld_q;
    end

    assign tail_index_o = tail;

endmodule

// ==== logic/gl_pkg.sv ====
package gl_pkg;

    // List geometry
    localparam int GL_ENTRIES = 8;          // Depth, one slot always kept free
    localparam int GL_IDX_W   = 3;          // Index width, log2 of the depth
    localparam int CNT_W      = GL_IDX_W + 1; // Occupancy count needs one extra bit

    // Writeback ports
    localparam int NUM_WB     = 2;          // Port 0 scalar, port 1 floating point

    // Datapath
    localparam int XLEN       = 32;         // Result and pc width
    localparam int RET_CNT_W  = 16;         // Retirement counter width

    typedef logic [GL_IDX_W-1:0] gl_index_t;

    // Coarse opcode class, only what graduation needs to know
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_STORE  = 3'd2,   // Finished at insertion
        OP_AMO    = 3'd3,   // Finished at insertion
        OP_FP     = 3'd4,
        OP_BRANCH = 3'd5
    } op_e;

    typedef enum logic [1:0] {
        EXC_NONE        = 2'd0,
        EXC_ILLEGAL     = 2'd1,
        EXC_LOAD_FAULT  = 2'd2,
        EXC_STORE_FAULT = 2'd3
    } exc_cause_e;

    // One dispatched instruction as it sits in the list
    typedef struct packed {
        logic             valid;
        op_e              op;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  result;
        exc_cause_e       cause;
    } gl_entry_t;

    // One writeback from an execution port
    typedef struct packed {
        logic             valid;
        gl_index_t        index;   // Entry being completed
        logic [XLEN-1:0]  result;
        exc_cause_e       cause;
    } gl_wb_t;

    // Retirement strobe towards the architectural state
    typedef struct packed {
        logic             valid;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  result;
    } retire_t;

    // Exception strobe towards the trap logic
    typedef struct packed {
        logic             valid;
        logic [XLEN-1:0]  pc;
        exc_cause_e       cause;
    } exc_t;

endpackage
